// ==== dmem_top.f ====
+incdir+logic
logic/dmem_pkg.sv
logic/dmem_lane_align.sv
logic/dmem_ram.sv
logic/dmem_load_extract.sv
logic/dmem_csr.sv
logic/dmem_top.sv
sim/dmem_clkgen.sv
sim/dmem_properties.sv
sim/dmem_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat dmem_top.f)) logic/dmem_cfg.svh

.PHONY: all run clean

all: run

obj_dir/Vdmem_tb: dmem_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module dmem_tb -f dmem_top.f -o Vdmem_tb

run: obj_dir/Vdmem_tb
	@out="$$(./obj_dir/Vdmem_tb)"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== sim/dmem_tb.sv ====
// self-checking testbench for the data-memory port, compiled as the simulation top
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module dmem_tb;

    localparam int win_size   = 1 << (`DMEM_IDX_W + 3);
    localparam int rand_count = 300;
    localparam int pair_count = 60;
    // reset, fill, random with gaps, pairs, window tests, register accesses, margin
    localparam int cycle_limit = 16 + win_size / 8 + 2 * rand_count + 2 * pair_count
                                 + 120 + 24 * 8 + 500;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    dmem_pkg::dmem_req_t  req;
    dmem_pkg::axil_req_t  axil_req;
    logic                 rsp_valid;
    dmem_pkg::dmem_rsp_t  rsp;
    dmem_pkg::axil_rsp_t  axil_rsp;

    // reference model of the window and the registers
    logic [7:0]           ref_mem [win_size];
    logic                 ref_en;
    dmem_pkg::dmem_addr_t ref_base;
    logic [31:0]          ref_fcnt;
    dmem_pkg::dmem_addr_t ref_faddr;

    dmem_pkg::dmem_rsp_t  exp_q [$];
    int                   cyc_q [$];
    string                name_q [$];

    int                   cycles = 0;
    int                   value_errs = 0;
    int                   other_errs = 0;
    integer               seed;
    string                test_name;

    dmem_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dmem_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .axil_req  (axil_req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .axil_rsp  (axil_rsp)
    );

    bind dmem_top dmem_properties u_properties (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp)
    );

    // expected response from the byte model, stores and fault counts update it
    function automatic dmem_pkg::dmem_rsp_t ref_access(input logic we,
                                                       input dmem_pkg::mem_op_e op,
                                                       input dmem_pkg::dmem_addr_t addr,
                                                       input dmem_pkg::dmem_data_t wdata);
        dmem_pkg::dmem_rsp_t  r;
        dmem_pkg::dmem_data_t val;
        logic [32:0]          off;
        int                   size;
        r    = '0;
        size = 1 << op[1:0];
        off  = {1'b0, addr - ref_base};
        if (!ref_en || (addr & 32'(size - 1)) != 0 || off + 33'(size) > 33'(win_size)) begin
            if (ref_fcnt != '1) begin
                ref_fcnt = ref_fcnt + 1;
            end
            ref_faddr = addr;
            r.err = 1'b1;
        end else if (we) begin
            for (int i = 0; i < size; i++) begin
                ref_mem[off[11:0] + 12'(i)] = wdata[i*8 +: 8];
            end
        end else begin
            val = '0;
            for (int i = 0; i < size; i++) begin
                val[i*8 +: 8] = ref_mem[off[11:0] + 12'(i)];
            end
            if (!op[2] && size < 8 && val[size*8-1]) begin
                val = val | ('1 << (size * 8));
            end
            r.rdata = val;
        end
        return r;
    endfunction

    function automatic dmem_pkg::mem_op_e rand_op();
        return dmem_pkg::mem_op_e'(3'({$random(seed)} % 7));
    endfunction

    // one request per call, entered and left on a falling edge
    task automatic access(input logic we, input dmem_pkg::mem_op_e op,
                          input dmem_pkg::dmem_addr_t addr, input dmem_pkg::dmem_data_t wdata);
        req_valid = 1'b1;
        req.we    = we;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        exp_q.push_back(ref_access(we, op, addr, wdata));
        cyc_q.push_back(cycles);
        name_q.push_back(test_name);
        @(negedge clk);
    endtask

    task automatic random_access();
        dmem_pkg::mem_op_e    op;
        dmem_pkg::dmem_addr_t off;
        op  = rand_op();
        off = 32'({$random(seed)} % win_size) & ~(32'(1 << op[1:0]) - 32'd1);
        access(1'($random(seed)), op, ref_base + off, {$random(seed), $random(seed)});
    endtask

    task automatic drain();
        req_valid = 1'b0;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.bready  = 1'b1;
        @(negedge clk);
        while (!axil_rsp.awready) begin
            @(negedge clk);
        end
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid) begin
            @(negedge clk);
        end
        if (axil_rsp.bresp != 2'b00) begin
            $display("write to offset %h answered with an error response", addr);
            other_errs++;
        end
        @(negedge clk);
        axil_req.bready = 1'b0;
        case (addr)
            `DMEM_REG_CTRL: ref_en = data[0];
            `DMEM_REG_BASE: ref_base = data & 32'hffff_f000;
            `DMEM_REG_FCNT: ref_fcnt = '0;
            default: ;
        endcase
    endtask

    task automatic check_reg(input string name, input logic [3:0] addr,
                             input logic [31:0] expected);
        logic [31:0] got;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) begin
            @(negedge clk);
        end
        got = axil_rsp.rdata;
        if (axil_rsp.rresp != 2'b00) begin
            $display("read of offset %h answered with an error response", addr);
            other_errs++;
        end
        @(negedge clk);
        axil_req.rready = 1'b0;
        if (got !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, got);
            value_errs++;
        end
    endtask

    // responses are stable between rising edges
    always @(negedge clk) begin : compare
        dmem_pkg::dmem_rsp_t e;
        string               n;
        if (rst_n && rsp_valid) begin
            // a request queued on this same edge is not due yet
            if (exp_q.size() == 0 || cyc_q[0] >= cycles) begin
                $display("response without a request in cycle %0d", cycles);
                other_errs++;
            end else begin
                e = exp_q.pop_front();
                void'(cyc_q.pop_front());
                n = name_q.pop_front();
                if (rsp !== e) begin
                    $display("FAIL %s: expected err=%b rdata=%h, actual err=%b rdata=%h",
                             n, e.err, e.rdata, rsp.err, rsp.rdata);
                    value_errs++;
                end
            end
        end else if (rst_n && exp_q.size() != 0 && cyc_q[0] < cycles) begin
            $display("no response for the request of cycle %0d", cyc_q[0]);
            other_errs++;
            void'(exp_q.pop_front());
            void'(cyc_q.pop_front());
            void'(name_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        dmem_pkg::dmem_addr_t a;
        dmem_pkg::mem_op_e    op;
        seed      = 32'ha2ee;
        req_valid = 1'b0;
        req       = '0;
        axil_req  = '0;
        ref_en    = 1'b1;
        ref_base  = `DMEM_BASE_RST;
        ref_fcnt  = '0;
        ref_faddr = '0;
        test_name = "reset";
        @(posedge rst_n);
        @(negedge clk);

        if (rsp_valid || axil_rsp.awready || axil_rsp.wready || axil_rsp.bvalid
            || axil_rsp.arready || axil_rsp.rvalid) begin
            $display("a valid or ready output is high after reset");
            other_errs++;
        end
        check_reg("reset_ctrl", `DMEM_REG_CTRL, 32'h1);
        check_reg("reset_base", `DMEM_REG_BASE, `DMEM_BASE_RST);

        // whole window written first so no load sees an unwritten word
        test_name = "fill";
        for (int w = 0; w < win_size / 8; w++) begin
            a = ref_base + 32'(w * 8);
            access(1'b1, dmem_pkg::op_d, a, {a ^ 32'h3c5a_96e1, ~a});
        end

        test_name = "sign_ext";
        a = ref_base + 32'h100;
        access(1'b1, dmem_pkg::op_d, a, 64'hff80_8000_7fff_8081);
        access(1'b0, dmem_pkg::op_b, a, '0);
        access(1'b0, dmem_pkg::op_bu, a, '0);
        access(1'b0, dmem_pkg::op_h, a, '0);
        access(1'b0, dmem_pkg::op_hu, a, '0);
        access(1'b0, dmem_pkg::op_h, a + 32'h2, '0);
        access(1'b0, dmem_pkg::op_w, a + 32'h4, '0);
        access(1'b0, dmem_pkg::op_wu, a + 32'h4, '0);
        access(1'b0, dmem_pkg::op_b, a + 32'h7, '0);
        access(1'b0, dmem_pkg::op_d, a, '0);

        test_name = "random";
        for (int i = 0; i < rand_count; i++) begin
            random_access();
            if (($random(seed) & 3) == 0) begin
                req_valid = 1'b0;
                @(negedge clk);
            end
        end

        // store then load of the same word on consecutive cycles
        test_name = "store_load";
        for (int i = 0; i < pair_count; i++) begin
            a  = ref_base + (32'({$random(seed)} % win_size) & ~32'h7);
            op = rand_op();
            access(1'b1, op, a + (32'($random(seed)) & 32'h7 & ~(32'(1 << op[1:0]) - 32'd1)),
                   {$random(seed), $random(seed)});
            access(1'b0, dmem_pkg::op_d, a, '0);
        end
        drain();

        test_name = "fault";
        axil_write(`DMEM_REG_FCNT, 32'h0);
        a = ref_base + 32'h200;
        access(1'b1, dmem_pkg::op_h, a + 32'h1, 64'h1111);
        access(1'b1, dmem_pkg::op_w, a + 32'h2, 64'h2222_2222);
        access(1'b1, dmem_pkg::op_d, a + 32'h4, 64'h3333_3333_3333_3333);
        access(1'b0, dmem_pkg::op_hu, a + 32'h3, '0);
        access(1'b1, dmem_pkg::op_b, ref_base - 32'h1, 64'h44);
        access(1'b1, dmem_pkg::op_d, ref_base - 32'h8, 64'h55);
        access(1'b0, dmem_pkg::op_d, ref_base + 32'h1000, '0);
        access(1'b1, dmem_pkg::op_w, ref_base + 32'hffc, 64'h6666_6666);
        access(1'b0, dmem_pkg::op_bu, ref_base + 32'hfff, '0);
        access(1'b0, dmem_pkg::op_d, a, '0);
        drain();
        check_reg("fcnt", `DMEM_REG_FCNT, ref_fcnt);
        check_reg("faddr", `DMEM_REG_FADDR, ref_faddr);
        axil_write(`DMEM_REG_FCNT, 32'h1234);
        check_reg("fcnt_clear", `DMEM_REG_FCNT, 32'h0);

        test_name = "move_base";
        axil_write(`DMEM_REG_BASE, 32'h4000_1234);
        check_reg("base_moved", `DMEM_REG_BASE, 32'h4000_1000);
        for (int i = 0; i < 40; i++) begin
            random_access();
        end
        access(1'b0, dmem_pkg::op_d, `DMEM_BASE_RST, '0);
        access(1'b1, dmem_pkg::op_w, `DMEM_BASE_RST + 32'h10, 64'h7777_7777);
        drain();
        check_reg("faddr_old", `DMEM_REG_FADDR, `DMEM_BASE_RST + 32'h10);

        test_name = "disabled";
        axil_write(`DMEM_REG_CTRL, 32'h0);
        check_reg("ctrl_off", `DMEM_REG_CTRL, 32'h0);
        for (int i = 0; i < 20; i++) begin
            random_access();
        end
        drain();
        axil_write(`DMEM_REG_CTRL, 32'h1);
        test_name = "enabled";
        for (int i = 0; i < 20; i++) begin
            random_access();
        end
        drain();
        check_reg("fcnt_end", `DMEM_REG_FCNT, ref_fcnt);

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/dmem_properties.sv ====
// concurrent checks on the core port and the register bus, attached to dmem_top by bind
`timescale 1ns/1ps
`default_nettype none

module dmem_properties (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                req_valid,
    input wire logic                rsp_valid,
    input wire dmem_pkg::dmem_rsp_t rsp,
    input wire dmem_pkg::axil_req_t axil_req,
    input wire dmem_pkg::axil_rsp_t axil_rsp
);

    // one response per request, exactly one cycle later
    rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |=> rsp_valid)
        else $error("rsp_valid missing one cycle after req_valid");

    no_rsp_without_req: assert property (@(posedge clk) disable iff (!rst_n)
        !req_valid |=> !rsp_valid)
        else $error("rsp_valid without a request in the previous cycle");

    // responses stay up until the master takes them
    bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    err_no_data: assert property (@(posedge clk) disable iff (!rst_n)
        !(rsp_valid && rsp.err && rsp.rdata != '0))
        else $error("fault response carries nonzero rdata");

endmodule

`default_nettype wire

// ==== sim/dmem_clkgen.sv ====
// testbench clock and reset source, 8 ns period with reset held low for 8 cycles
`timescale 1ns/1ps
`default_nettype none

module dmem_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== logic/dmem_top.sv ====
// data-memory port top level: core request port plus AXI4-Lite register port
`timescale 1ns/1ps
`default_nettype none

module dmem_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req_valid,
    input  wire dmem_pkg::dmem_req_t req,
    input  wire dmem_pkg::axil_req_t axil_req,
    output logic                     rsp_valid,
    output dmem_pkg::dmem_rsp_t      rsp,
    output dmem_pkg::axil_rsp_t      axil_rsp
);

    logic                 ctrl_en;
    dmem_pkg::dmem_addr_t win_base;
    dmem_pkg::dmem_idx_t  ram_idx;
    logic                 ram_we;
    dmem_pkg::dmem_strb_t ram_strb;
    dmem_pkg::dmem_data_t ram_wdata;
    dmem_pkg::dmem_data_t ram_rdata;
    logic                 fault;
    dmem_pkg::mem_op_e    ld_op;
    logic [2:0]           ld_off;
    logic                 ld_fault;
    logic                 is_load;

    dmem_csr u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .axil_req   (axil_req),
        .fault      (fault),
        .fault_addr (req.addr),
        .axil_rsp   (axil_rsp),
        .ctrl_en    (ctrl_en),
        .win_base   (win_base)
    );

    dmem_lane_align u_lane_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .ctrl_en    (ctrl_en),
        .win_base   (win_base),
        .ram_idx    (ram_idx),
        .ram_we     (ram_we),
        .ram_strb   (ram_strb),
        .ram_wdata  (ram_wdata),
        .fault      (fault),
        .ld_op      (ld_op),
        .ld_off     (ld_off),
        .ld_fault   (ld_fault),
        .rsp_valid  (rsp_valid)
    );

    dmem_ram u_ram (
        .clk   (clk),
        .idx   (ram_idx),
        .we    (ram_we),
        .strb  (ram_strb),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // loads return data, stores return zero
    always_ff @(posedge clk) begin
        is_load <= req_valid & ~req.we;
    end

    dmem_load_extract u_load_extract (
        .rsp_valid (rsp_valid),
        .word      (ram_rdata),
        .op        (ld_op),
        .off       (ld_off),
        .fault     (ld_fault),
        .is_load   (is_load),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// ==== logic/dmem_csr.sv ====
// AXI4-Lite register block: enable, window base, fault counter and last fault address
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module dmem_csr (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire dmem_pkg::axil_req_t  axil_req,
    input  wire logic                 fault,
    input  wire dmem_pkg::dmem_addr_t fault_addr,
    output dmem_pkg::axil_rsp_t       axil_rsp,
    output logic                      ctrl_en,
    output dmem_pkg::dmem_addr_t      win_base
);

    logic                         awready;
    logic                         wready;
    logic                         bvalid;
    logic                         arready;
    logic                         rvalid;
    logic [`DMEM_AXIL_DATA_W-1:0] rdata;
    logic [`DMEM_AXIL_DATA_W-1:0] fcnt;
    dmem_pkg::dmem_addr_t         faddr;
    dmem_pkg::dmem_addr_t         base_wr;
    logic [`DMEM_AXIL_DATA_W-1:0] fcnt_base;
    logic                         wr_hs;
    logic                         rd_hs;

    assign wr_hs = axil_req.awvalid & awready & axil_req.wvalid & wready;
    assign rd_hs = axil_req.arvalid & arready;

    // address and data accepted together, one write in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= axil_req.awvalid & axil_req.wvalid & ~awready & ~bvalid;
            wready  <= axil_req.awvalid & axil_req.wvalid & ~wready & ~bvalid;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bvalid && axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= axil_req.arvalid & ~arready & ~rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // strobed bytes merged into the base, page offset always cleared
    always_comb begin
        base_wr = win_base;
        for (int i = 0; i < `DMEM_AXIL_DATA_W/8; i++) begin
            if (axil_req.wstrb[i]) begin
                base_wr[i*8 +: 8] = axil_req.wdata[i*8 +: 8];
            end
        end
        base_wr[11:0] = 12'h000;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_en  <= 1'b1;
            win_base <= `DMEM_BASE_RST;
        end else if (wr_hs) begin
            if (axil_req.awaddr == `DMEM_REG_CTRL && axil_req.wstrb[0]) begin
                ctrl_en <= axil_req.wdata[0];
            end
            if (axil_req.awaddr == `DMEM_REG_BASE) begin
                win_base <= base_wr;
            end
        end
    end

    // clear first, then count a fault from the same cycle
    assign fcnt_base = (wr_hs && axil_req.awaddr == `DMEM_REG_FCNT) ? '0 : fcnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fcnt  <= '0;
            faddr <= '0;
        end else begin
            if (fault && fcnt_base != '1) begin
                fcnt <= fcnt_base + 1'b1;
            end else begin
                fcnt <= fcnt_base;
            end
            if (fault) begin
                faddr <= fault_addr;
            end
        end
    end

    // read data captured at the address handshake
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            case (axil_req.araddr)
                `DMEM_REG_CTRL:  rdata <= {{(`DMEM_AXIL_DATA_W-1){1'b0}}, ctrl_en};
                `DMEM_REG_BASE:  rdata <= win_base;
                `DMEM_REG_FCNT:  rdata <= fcnt;
                `DMEM_REG_FADDR: rdata <= faddr;
                default:         rdata <= '0;
            endcase
        end
    end

    // every access answers OKAY
    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = awready;
        axil_rsp.wready  = wready;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = 2'b00;
        axil_rsp.arready = arready;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = 2'b00;
    end

endmodule

`default_nettype wire

// ==== logic/dmem_load_extract.sv ====
// response stage: picks the loaded lane from the RAM word and extends it to 64 bits
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module dmem_load_extract (
    input  wire logic                 rsp_valid,
    input  wire dmem_pkg::dmem_data_t word,
    input  wire dmem_pkg::mem_op_e    op,
    input  wire logic [2:0]           off,
    input  wire logic                 fault,
    input  wire logic                 is_load,
    output dmem_pkg::dmem_rsp_t       rsp
);

    dmem_pkg::dmem_data_t lane;
    dmem_pkg::dmem_data_t ext;
    logic                 uns;

    // addressed byte moved down to bit 0
    assign lane = word >> {off, 3'b000};
    assign uns  = op[2];

    always_comb begin
        case (op[1:0])
            2'd0: begin
                if (uns) begin
                    ext = {{(`DMEM_DATA_W-8){1'b0}}, lane[7:0]};
                end else begin
                    ext = {{(`DMEM_DATA_W-8){lane[7]}}, lane[7:0]};
                end
            end
            2'd1: begin
                if (uns) begin
                    ext = {{(`DMEM_DATA_W-16){1'b0}}, lane[15:0]};
                end else begin
                    ext = {{(`DMEM_DATA_W-16){lane[15]}}, lane[15:0]};
                end
            end
            2'd2: begin
                if (uns) begin
                    ext = {{(`DMEM_DATA_W-32){1'b0}}, lane[31:0]};
                end else begin
                    ext = {{(`DMEM_DATA_W-32){lane[31]}}, lane[31:0]};
                end
            end
            default: begin
                ext = lane;
            end
        endcase
    end

    // stores and faults return zero data
    always_comb begin
        rsp = '0;
        if (rsp_valid) begin
            rsp.err = fault;
            if (is_load && !fault) begin
                rsp.rdata = ext;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/dmem_ram.sv ====
// word-wide data RAM with byte-strobe writes and one cycle of read latency
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module dmem_ram (
    input  wire logic                 clk,
    input  wire dmem_pkg::dmem_idx_t  idx,
    input  wire logic                 we,
    input  wire dmem_pkg::dmem_strb_t strb,
    input  wire dmem_pkg::dmem_data_t wdata,
    output dmem_pkg::dmem_data_t      rdata
);

    localparam int depth = 1 << `DMEM_IDX_W;

    dmem_pkg::dmem_data_t mem [depth];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DMEM_STRB_W; i++) begin
            if (we && strb[i]) begin
                mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
    end

    // read before write on the same word
    always_ff @(posedge clk) begin
        rdata <= mem[idx];
    end

endmodule

`default_nettype wire

// ==== logic/dmem_lane_align.sv ====
// request stage of the memory port: alignment and window check, store lanes, response pipeline
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module dmem_lane_align (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req_valid,
    input  wire dmem_pkg::dmem_req_t req,
    input  wire logic                ctrl_en,
    input  wire dmem_pkg::dmem_addr_t win_base,
    output dmem_pkg::dmem_idx_t      ram_idx,
    output logic                     ram_we,
    output dmem_pkg::dmem_strb_t     ram_strb,
    output dmem_pkg::dmem_data_t     ram_wdata,
    output logic                     fault,
    output dmem_pkg::mem_op_e        ld_op,
    output logic [2:0]               ld_off,
    output logic                     ld_fault,
    output logic                     rsp_valid
);

    // window size in bytes, one bit wider than an address
    localparam logic [`DMEM_ADDR_W:0] win_bytes = (`DMEM_ADDR_W+1)'(1) << (`DMEM_IDX_W + 3);

    dmem_pkg::dmem_addr_t     win_off;
    logic [`DMEM_ADDR_W:0]    win_end;
    logic [3:0]               size_bytes;
    dmem_pkg::dmem_strb_t     size_mask;
    logic                     misalign;
    logic                     out_win;

    // addresses below the base wrap to a large offset and land outside
    assign win_off = req.addr - win_base;

    always_comb begin
        case (req.op[1:0])
            2'd0: begin
                size_bytes = 4'd1;
                size_mask  = 8'h01;
                misalign   = 1'b0;
            end
            2'd1: begin
                size_bytes = 4'd2;
                size_mask  = 8'h03;
                misalign   = req.addr[0];
            end
            2'd2: begin
                size_bytes = 4'd4;
                size_mask  = 8'h0f;
                misalign   = |req.addr[1:0];
            end
            default: begin
                size_bytes = 4'd8;
                size_mask  = 8'hff;
                misalign   = |req.addr[2:0];
            end
        endcase
    end

    assign win_end = {1'b0, win_off} + (`DMEM_ADDR_W+1)'(size_bytes);
    assign out_win = win_end > win_bytes;

    assign fault = req_valid & (~ctrl_en | misalign | out_win);

    // store path, lanes follow the low address bits
    assign ram_idx   = win_off[`DMEM_IDX_W+2:3];
    assign ram_we    = req_valid & req.we & ~fault;
    assign ram_strb  = size_mask << req.addr[2:0];
    assign ram_wdata = req.wdata << {req.addr[2:0], 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    // carried into the response cycle next to the RAM read
    always_ff @(posedge clk) begin
        ld_op    <= req.op;
        ld_off   <= req.addr[2:0];
        ld_fault <= fault;
    end

endmodule

`default_nettype wire

// ==== logic/dmem_pkg.sv ====
// shared types of the data-memory port, referenced by scoped name from the RTL and testbench
`default_nettype none

`include "dmem_cfg.svh"

package dmem_pkg;

    typedef logic [`DMEM_ADDR_W-1:0] dmem_addr_t;
    typedef logic [`DMEM_DATA_W-1:0] dmem_data_t;
    typedef logic [`DMEM_IDX_W-1:0]  dmem_idx_t;
    typedef logic [`DMEM_STRB_W-1:0] dmem_strb_t;

    // funct3 encoding, low bits are log2 of size, bit 2 is unsigned
    typedef enum logic [2:0] {
        op_b  = 3'b000,
        op_h  = 3'b001,
        op_w  = 3'b010,
        op_d  = 3'b011,
        op_bu = 3'b100,
        op_hu = 3'b101,
        op_wu = 3'b110
    } mem_op_e;

    typedef struct packed {
        logic       we;
        mem_op_e    op;
        dmem_addr_t addr;
        dmem_data_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic       err;
        dmem_data_t rdata;
    } dmem_rsp_t;

    // master to slave
    typedef struct packed {
        logic                          awvalid;
        logic [`DMEM_AXIL_ADDR_W-1:0]  awaddr;
        logic                          wvalid;
        logic [`DMEM_AXIL_DATA_W-1:0]  wdata;
        logic [`DMEM_AXIL_DATA_W/8-1:0] wstrb;
        logic                          bready;
        logic                          arvalid;
        logic [`DMEM_AXIL_ADDR_W-1:0]  araddr;
        logic                          rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic                         awready;
        logic                         wready;
        logic                         bvalid;
        logic [1:0]                   bresp;
        logic                         arready;
        logic                         rvalid;
        logic [`DMEM_AXIL_DATA_W-1:0] rdata;
        logic [1:0]                   rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

// ==== logic/dmem_cfg.svh ====
// widths, RAM depth, register map and reset base, include wherever these values are needed
`ifndef DMEM_CFG_SVH
`define DMEM_CFG_SVH

// core-side widths
`define DMEM_ADDR_W 32
`define DMEM_DATA_W 64
`define DMEM_STRB_W 8

// 512 words of 64 bits, 4 KiB window
`define DMEM_IDX_W 9

// window base after reset, always 4 KiB aligned
`define DMEM_BASE_RST 32'h8000_0000

// register block bus widths
`define DMEM_AXIL_ADDR_W 4
`define DMEM_AXIL_DATA_W 32

// register offsets
`define DMEM_REG_CTRL  4'h0
`define DMEM_REG_BASE  4'h4
`define DMEM_REG_FCNT  4'h8
`define DMEM_REG_FADDR 4'hC

`endif
